// File: hw/alu.sv
`timescale 1ns/10ps

module alu import execute_pkg::*; (
  input  logic [31:0] a,
  input  logic [31:0] b,
  input  alu_op_type  op,
  output logic [31:0] res
);

  always_comb begin
    case (op)
      alu_add: res = a + b;
      alu_sub: res = a - b;
      alu_and: res = a & b;
      alu_or:  res = a | b;
      alu_xor: res = a ^ b;
      alu_sll: res = a << b[4:0];   // Shift amount in low five bits
      alu_srl: res = a >> b[4:0];
      default: res = '0;
    endcase
  end

endmodule

// File: hw/decode_stage.sv
`timescale 1ns/10ps
`include "execute_consts.svh"

module decode_stage import execute_pkg::*; (
  input  logic           clock,
  input  logic           reset,
  input  logic           instr_valid,
  input  instr_word_type instr_word,
  input  logic           stall,
  input  forward_type    fwd,
  input  logic [31:0]    rdata1,
  input  logic [31:0]    rdata2,
  output logic           instr_ready,
  output logic [4:0]     raddr1,
  output logic [4:0]     raddr2,
  output decoded_type    dec
);

  logic        running;
  logic        accept;
  decoded_type item_d;
  decoded_type item_q;

  assign instr_ready = running & ~stall;
  assign accept = instr_valid & instr_ready;
  assign raddr1 = instr_word.i_fmt.rs1;
  assign raddr2 = instr_word.r_fmt.rs2;

  always_comb begin
    item_d = '0;
    item_d.valid = accept;   // Bubble when nothing transfers
    item_d.instr = instr_word;
    item_d.rd = instr_word.i_fmt.rd;
    item_d.imm = {{20{instr_word.i_fmt.imm12[11]}}, instr_word.i_fmt.imm12};
    item_d.alu_op = alu_add;
    item_d.rdata1 = (fwd.wren && fwd.waddr == raddr1) ? fwd.wdata : rdata1;
    item_d.rdata2 = (fwd.wren && fwd.waddr == raddr2) ? fwd.wdata : rdata2;
    case (instr_word.r_fmt.opcode)
      `OPCODE_OP_IMM: begin
        item_d.use_imm = 1'b1;
        item_d.wren = 1'b1;
        case (instr_word.i_fmt.funct3)
          `FUNCT3_ADD: item_d.alu_op = alu_add;
          `FUNCT3_AND: item_d.alu_op = alu_and;
          `FUNCT3_OR:  item_d.alu_op = alu_or;
          `FUNCT3_XOR: item_d.alu_op = alu_xor;
          `FUNCT3_SLL: begin
            item_d.alu_op = alu_sll;
            item_d.illegal = (instr_word.r_fmt.funct7 != 7'd0);   // Upper shamt bits
          end
          default: item_d.illegal = 1'b1;
        endcase
      end
      `OPCODE_OP: begin
        item_d.wren = 1'b1;
        if (instr_word.r_fmt.funct7 == `FUNCT7_MULDIV) begin
          item_d.mult = (instr_word.r_fmt.funct3 == `FUNCT3_ADD);   // MUL only
          item_d.illegal = (instr_word.r_fmt.funct3 != `FUNCT3_ADD);
        end else if (instr_word.r_fmt.funct7 == `FUNCT7_SUB) begin
          item_d.alu_op = alu_sub;
          item_d.illegal = (instr_word.r_fmt.funct3 != `FUNCT3_ADD);
        end else if (instr_word.r_fmt.funct7 == 7'd0) begin
          case (instr_word.r_fmt.funct3)
            `FUNCT3_ADD: item_d.alu_op = alu_add;
            `FUNCT3_AND: item_d.alu_op = alu_and;
            `FUNCT3_OR:  item_d.alu_op = alu_or;
            `FUNCT3_XOR: item_d.alu_op = alu_xor;
            `FUNCT3_SLL: item_d.alu_op = alu_sll;
            `FUNCT3_SRL: item_d.alu_op = alu_srl;
            default:     item_d.illegal = 1'b1;
          endcase
        end else begin
          item_d.illegal = 1'b1;
        end
      end
      `OPCODE_LUI: begin
        item_d.lui = 1'b1;
        item_d.wren = 1'b1;
        item_d.imm = {instr_word.i_fmt.imm12, instr_word.i_fmt.rs1,
                      instr_word.i_fmt.funct3, 12'd0};
      end
      `OPCODE_SYSTEM: begin
        item_d.ebreak = (instr_word.i_fmt.imm12 == 12'd1) && (instr_word.i_fmt.rs1 == 5'd0) &&
                        (instr_word.i_fmt.funct3 == 3'd0) && (instr_word.i_fmt.rd == 5'd0);
        item_d.illegal = ~item_d.ebreak;
      end
      default: item_d.illegal = 1'b1;
    endcase
  end

  // Late bypass for the item now completing in execute
  always_comb begin
    dec = item_q;
    if (fwd.wren && fwd.waddr == item_q.instr.r_fmt.rs1) begin
      dec.rdata1 = fwd.wdata;
    end
    if (fwd.wren && fwd.waddr == item_q.instr.r_fmt.rs2) begin
      dec.rdata2 = fwd.wdata;
    end
  end

  always_ff @(posedge clock) begin
    if (reset == 0) begin
      running <= 1'b0;
      item_q <= '0;
    end else begin
      running <= 1'b1;
      if (!stall) begin
        item_q <= item_d;
      end
    end
  end

  word_held_until_accept: assert property (@(posedge clock) disable iff (!reset)
    instr_valid && !instr_ready |=> instr_valid && $stable(instr_word));

endmodule

// File: hw/execute_consts.svh
`ifndef EXECUTE_CONSTS_SVH
`define EXECUTE_CONSTS_SVH

`define OPCODE_OP        7'b0110011
`define OPCODE_OP_IMM    7'b0010011
`define OPCODE_LUI       7'b0110111
`define OPCODE_SYSTEM    7'b1110011

`define FUNCT7_MULDIV    7'b0000001
`define FUNCT7_SUB       7'b0100000

`define FUNCT3_ADD       3'b000
`define FUNCT3_SLL       3'b001
`define FUNCT3_XOR       3'b100
`define FUNCT3_SRL       3'b101
`define FUNCT3_OR        3'b110
`define FUNCT3_AND       3'b111

`define CAUSE_ILLEGAL    4'd2
`define CAUSE_BREAKPOINT 4'd3

`define MUL_CYCLES       32

`endif

// File: hw/execute_core.sv
`timescale 1ns/10ps

module execute_core import execute_pkg::*; (
  input  logic           clock,
  input  logic           reset,
  input  logic           instr_valid,
  input  instr_word_type instr_word,
  output logic           instr_ready,
  output writeback_type  wb
);

  logic [4:0]  raddr1;
  logic [4:0]  raddr2;
  logic [31:0] rdata1;
  logic [31:0] rdata2;
  decoded_type dec;
  logic        stall;
  forward_type fwd;
  logic [31:0] alu_a;
  logic [31:0] alu_b;
  logic [31:0] alu_res;
  alu_op_type  alu_op;
  logic        mul_start;
  logic        mul_done;
  logic [31:0] mul_a;
  logic [31:0] mul_b;
  logic [31:0] mul_product;

  decode_stage decode (
    .clock, .reset, .instr_valid, .instr_word, .stall, .fwd,
    .rdata1, .rdata2, .instr_ready, .raddr1, .raddr2, .dec
  );

  execute_stage execute (
    .clock, .reset, .dec, .alu_res, .mul_done, .mul_product,
    .alu_a, .alu_b, .alu_op, .mul_start, .mul_a, .mul_b, .stall, .fwd, .wb
  );

  alu alu_unit (.a(alu_a), .b(alu_b), .op(alu_op), .res(alu_res));

  multiplier mul_unit (
    .clock, .reset, .start(mul_start), .a(mul_a), .b(mul_b),
    .done(mul_done), .product(mul_product)
  );

  register_file regfile (.clock, .reset, .raddr1, .raddr2, .fwd, .rdata1, .rdata2);

endmodule

// File: hw/execute_pkg.sv
package execute_pkg;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_type;

  typedef struct packed {
    logic [11:0] imm12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_type;

  typedef union packed {
    r_fmt_type r_fmt;
    i_fmt_type i_fmt;
  } instr_word_type;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_sll,
    alu_srl
  } alu_op_type;

  typedef struct packed {
    logic           valid;
    instr_word_type instr;   // Kept for etval
    logic [4:0]     rd;
    logic [31:0]    rdata1;
    logic [31:0]    rdata2;
    logic [31:0]    imm;
    logic           use_imm;
    logic           wren;
    alu_op_type     alu_op;
    logic           mult;
    logic           lui;
    logic           ebreak;
    logic           illegal;
  } decoded_type;

  typedef struct packed {
    logic        wren;
    logic [4:0]  waddr;
    logic [31:0] wdata;
  } forward_type;

  typedef struct packed {
    logic        valid;
    logic [4:0]  rd;
    logic [31:0] wdata;
    logic        exception;
    logic [3:0]  ecause;
    logic [31:0] etval;
  } writeback_type;

endpackage

// File: hw/execute_stage.sv
`timescale 1ns/10ps
`include "execute_consts.svh"

module execute_stage import execute_pkg::*; (
  input  logic          clock,
  input  logic          reset,
  input  decoded_type   dec,
  input  logic [31:0]   alu_res,
  input  logic          mul_done,
  input  logic [31:0]   mul_product,
  output logic [31:0]   alu_a,
  output logic [31:0]   alu_b,
  output alu_op_type    alu_op,
  output logic          mul_start,
  output logic [31:0]   mul_a,
  output logic [31:0]   mul_b,
  output logic          stall,
  output forward_type   fwd,
  output writeback_type wb
);

  decoded_type   r;
  logic          mul_pending;
  logic          wren;
  logic [31:0]   wdata;
  logic          exception;
  logic [3:0]    ecause;
  writeback_type wb_next;

  always_comb begin
    alu_a = r.rdata1;
    alu_b = r.use_imm ? r.imm : r.rdata2;
    alu_op = r.alu_op;
    mul_a = r.rdata1;
    mul_b = r.rdata2;

    mul_start = r.valid & r.mult & ~mul_pending;   // First cycle of MUL
    stall = r.valid & r.mult & ~mul_done;

    wdata = alu_res;
    if (r.lui) begin
      wdata = r.imm;
    end else if (r.mult) begin
      wdata = mul_product;
    end
    wren = r.wren;

    exception = 1'b0;
    ecause = '0;
    if (r.illegal) begin
      exception = 1'b1;
      ecause = `CAUSE_ILLEGAL;
    end else if (r.ebreak) begin
      exception = 1'b1;
      ecause = `CAUSE_BREAKPOINT;
    end
    if (exception || r.rd == 5'd0) begin
      wren = 1'b0;
      wdata = '0;
    end
    if (!r.valid || stall) begin
      wren = 1'b0;
    end

    fwd.wren = wren;
    fwd.waddr = r.rd;
    fwd.wdata = wdata;

    wb_next.valid = r.valid & ~stall;
    wb_next.rd = r.rd;
    wb_next.wdata = wdata;
    wb_next.exception = exception;
    wb_next.ecause = ecause;
    wb_next.etval = exception ? r.instr : '0;
  end

  always_ff @(posedge clock) begin
    if (reset == 0) begin
      r <= '0;
      mul_pending <= 1'b0;
      wb <= '0;
    end else begin
      if (!stall) begin
        r <= dec;
      end
      if (mul_start) begin
        mul_pending <= 1'b1;
      end else if (mul_done) begin
        mul_pending <= 1'b0;
      end
      wb <= wb_next;
    end
  end

  done_only_for_pending_mul: assert property (@(posedge clock) disable iff (!reset)
    mul_done |-> r.valid && r.mult && mul_pending);

endmodule

// File: hw/multiplier.sv
`timescale 1ns/10ps
`include "execute_consts.svh"

module multiplier (
  input  logic        clock,
  input  logic        reset,
  input  logic        start,
  input  logic [31:0] a,
  input  logic [31:0] b,
  output logic        done,
  output logic [31:0] product
);

  localparam int count_width = $clog2(`MUL_CYCLES + 1);

  logic                   busy;
  logic [count_width-1:0] count;
  logic [31:0]            acc;
  logic [31:0]            mcand;
  logic [31:0]            mplier;

  assign product = acc;

  always_ff @(posedge clock) begin
    if (reset == 0) begin
      busy <= 1'b0;
      done <= 1'b0;
      count <= '0;
    end else begin
      done <= 1'b0;
      if (start) begin
        busy <= 1'b1;
        count <= count_width'(`MUL_CYCLES);
      end else if (busy) begin
        count <= count - 1'b1;
        if (count == count_width'(1)) begin   // Last bit
          busy <= 1'b0;
          done <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (start) begin
      acc <= '0;
      mcand <= a;
      mplier <= b;
    end else if (busy) begin
      if (mplier[0]) begin
        acc <= acc + mcand;
      end
      mcand <= mcand << 1;
      mplier <= mplier >> 1;
    end
  end

  no_start_when_busy: assert property (@(posedge clock) disable iff (!reset)
    start |-> !busy);

endmodule

// File: hw/register_file.sv
`timescale 1ns/10ps

module register_file import execute_pkg::*; (
  input  logic        clock,
  input  logic        reset,
  input  logic [4:0]  raddr1,
  input  logic [4:0]  raddr2,
  input  forward_type fwd,
  output logic [31:0] rdata1,
  output logic [31:0] rdata2
);

  logic [31:0] regs [32];

  assign rdata1 = (raddr1 == 5'd0) ? '0 : regs[raddr1];   // x0 reads zero
  assign rdata2 = (raddr2 == 5'd0) ? '0 : regs[raddr2];

  always_ff @(posedge clock) begin
    if (reset == 0) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (fwd.wren && fwd.waddr != 5'd0) begin
      regs[fwd.waddr] <= fwd.wdata;
    end
  end

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the execute core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f verilog.f --top-module tb_top
./obj_dir/Vtb_top > sim.log 2>&1
cat sim.log

if grep -q "tests failed" sim.log; then
  echo "simulation reported a failure, see sim.log"
  exit 1
fi
echo "simulation finished without reported failure"

// File: verification/execute_testdata.txt
// instr valid rd wdata exception cause, all hex, one instruction per line in issue order
// each line is the word driven and the writeback report expected for it
00500093 1 01 00000005 0 0   // addi x1, x0, 5
00708113 1 02 0000000c 0 0
fff10193 1 03 0000000b 0 0   // addi x3, x2, -1
80018213 1 04 fffff80b 0 0   // addi x4, x3, -2048
ff027293 1 05 fffff800 0 0   // andi x5, x4, -16
0a00e313 1 06 000000a5 0 0
fff34393 1 07 ffffff5a 0 0   // xori x7, x6, -1
00409413 1 08 00000050 0 0   // slli x8, x1, 4
003104b3 1 09 00000017 0 0
40208533 1 0a fffffff9 0 0   // sub x10, x1, x2
0043f5b3 1 0b fffff80a 0 0
00836633 1 0c 000000f5 0 0
001646b3 1 0d 000000f0 0 0   // xor x13, x12, x1
00809733 1 0e 00050000 0 0   // sll x14, x1, x8
001257b3 1 0f 07ffffc0 0 0   // srl x15, x4, x1
12345837 1 10 12345000 0 0   // lui x16, 0x12345
67880813 1 10 12345678 0 0
023808b3 1 11 c83fb728 0 0   // mul x17, x16, x3
02a38933 1 12 0000048a 0 0   // mul x18, x7, x10
012889b3 1 13 c83fbbb2 0 0
00100073 1 00 00000000 1 3   // ebreak
023140b3 1 01 00000000 1 2   // div x1, x2, x3 not supported
ffffffff 1 1f 00000000 1 2
00008a13 1 14 00000005 0 0   // x1 still 5
12308013 1 00 00000000 0 0   // addi x0, x1, 0x123
00100ab3 1 15 00000005 0 0   // add x21, x0, x1
015a8b33 1 16 0000000a 0 0

// File: verification/tb_checker.sv
`timescale 1ns/10ps

module tb_checker import execute_pkg::*; #(
  parameter int entry_count = 1
) (
  input  logic          clock,
  input  logic          reset,
  input  logic          instr_ready,
  input  writeback_type wb,
  input  logic [74:0]   test_table [entry_count],
  output int            error_count,
  output int            report_count,
  output int            longest_stall
);

  typedef struct packed {
    logic [31:0] instr;
    logic        valid;
    logic [4:0]  rd;
    logic [31:0] wdata;
    logic        exception;
    logic [3:0]  cause;
  } test_entry_type;

  test_entry_type expected;
  int             errors = 0;
  int             reports = 0;
  int             stall_run = 0;
  int             longest = 0;

  assign error_count = errors;
  assign report_count = reports;
  assign longest_stall = longest;

  task automatic compare_value(input string name, input logic [31:0] want,
                               input logic [31:0] got);
    if (got !== want) begin
      $display("FAILED %s at report %0d: expected %h, got %h", name, reports, want, got);
      errors++;
    end
  endtask

  // Outputs change on the rising edge, so look at them on the falling one
  always @(negedge clock) begin
    if (!reset) begin
      if (wb.valid !== 1'b0 || instr_ready !== 1'b0) begin
        $display("a control output was active during reset");
        errors++;
      end
    end else begin
      if (instr_ready === 1'b0) begin
        stall_run++;
        if (stall_run > longest) begin
          longest = stall_run;
        end
      end else begin
        stall_run = 0;
      end
      if (wb.valid === 1'b1) begin
        if (reports >= entry_count) begin
          $display("an extra writeback report arrived beyond the %0d expected", entry_count);
          errors++;
        end else begin
          expected = test_table[reports];
          compare_value("wb.rd", {27'd0, expected.rd}, {27'd0, wb.rd});
          compare_value("wb.wdata", expected.wdata, wb.wdata);
          compare_value("wb.exception", {31'd0, expected.exception}, {31'd0, wb.exception});
          compare_value("wb.ecause", {28'd0, expected.cause}, {28'd0, wb.ecause});
          if (expected.exception) begin
            compare_value("wb.etval", expected.instr, wb.etval);   // Trapping word itself
          end
        end
        reports++;
      end
    end
  end

endmodule

// File: verification/tb_clock.sv
`timescale 1ns/10ps

module tb_clock (
  output logic clock
);

  initial begin
    clock = 1'b0;
    forever begin
      #2 clock = ~clock;   // 4 ns period
    end
  end

endmodule

// File: verification/tb_top.sv
`timescale 1ns/10ps
`include "execute_consts.svh"

module tb_top import execute_pkg::*; ();

  localparam int entry_count = 27;
  localparam int field_count = 6;
  localparam int cycle_limit = entry_count * (`MUL_CYCLES + 8) + 50;

  typedef struct packed {
    logic [31:0] instr;
    logic        valid;
    logic [4:0]  rd;
    logic [31:0] wdata;
    logic        exception;
    logic [3:0]  cause;
  } test_entry_type;

  logic [31:0]    raw_words [entry_count * field_count];
  logic [74:0]    test_table [entry_count];
  logic           clock;
  logic           reset;
  logic           instr_valid;
  instr_word_type instr_word;
  logic           instr_ready;
  writeback_type  wb;
  int             error_count;
  int             report_count;
  int             longest_stall;
  int             cycle_count = 0;

  tb_clock clock_gen (.clock);

  execute_core uut (.clock, .reset, .instr_valid, .instr_word, .instr_ready, .wb);

  tb_checker #(.entry_count(entry_count)) wb_monitor (
    .clock, .reset, .instr_ready, .wb, .test_table, .error_count, .report_count,
    .longest_stall
  );

  task automatic load_table();
    test_entry_type entry;
    $readmemh("verification/execute_testdata.txt", raw_words);
    for (int i = 0; i < entry_count; i++) begin
      entry.instr = raw_words[i * field_count];
      entry.valid = raw_words[i * field_count + 1][0];
      entry.rd = raw_words[i * field_count + 2][4:0];
      entry.wdata = raw_words[i * field_count + 3];
      entry.exception = raw_words[i * field_count + 4][0];
      entry.cause = raw_words[i * field_count + 5][3:0];
      test_table[i] = entry;
    end
  endtask

  task automatic idle_cycles(input int count);
    repeat (count) begin
      @(posedge clock);
      #1;
    end
  endtask

  task automatic send_instr(input logic [31:0] word);
    logic accepted;
    instr_valid = 1'b1;
    instr_word = word;
    accepted = 1'b0;
    while (!accepted) begin
      accepted = instr_ready;   // Ready only depends on registers
      @(posedge clock);
      #1;
    end
    instr_valid = 1'b0;
  endtask

  initial begin
    test_entry_type current;
    int             total_errors;
    reset = 1'b0;
    instr_valid = 1'b0;
    instr_word = '0;
    void'($urandom(32'h7769));
    load_table();
    repeat (3) @(posedge clock);
    #1;
    reset = 1'b1;
    for (int i = 0; i < entry_count; i++) begin
      if (i >= 4 && $urandom % 4 == 0) begin   // ADDI chain stays back to back
        idle_cycles(1 + $urandom % 3);
      end
      current = test_table[i];
      send_instr(current.instr);
    end
    wait (report_count >= entry_count);
    idle_cycles(5);   // Room for stray reports
    total_errors = error_count;
    if (longest_stall < `MUL_CYCLES) begin
      $display("instr_ready was never held low for a whole multiply");
      total_errors++;
    end
    $display("errors: %0d, reports: %0d of %0d", total_errors, report_count, entry_count);
    if (total_errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("timeout after %0d cycles with %0d of %0d reports received",
               cycle_count, report_count, entry_count);
      $display("tests failed");
      $finish;
    end
  end

endmodule

// File: verilog.f
+incdir+hw
hw/execute_pkg.sv
hw/alu.sv
hw/multiplier.sv
hw/register_file.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/execute_core.sv
verification/tb_clock.sv
verification/tb_checker.sv
verification/tb_top.sv
